// File: list.f
src/md_lr_pkg.sv
src/bank_ram.sv
src/clustered_grid_mem.sv
src/charge_spreader.sv
src/force_gather.sv
src/md_lr_seqr.sv
src/md_lr_top.sv
verification/md_lr_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the particle-mesh testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module md_lr_tb -f list.f -o md_lr_sim || exit 1
out=$(./obj_dir/md_lr_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "All tests passed" && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }

// File: src/bank_ram.sv
// Single-port synchronous RAM
`timescale 1ns/1ps

module bank_ram #(
  parameter int  DEPTH   = 8,
  parameter type entry_t = logic [7:0]
) (
  input  logic                     clk,
  input  logic                     en,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  entry_t                   wdata,
  output entry_t                   rdata
);

  entry_t mem [DEPTH];                 // Storage array

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;            // Write port
      end
      rdata <= mem[addr];              // Old data on collision
    end
  end

endmodule

// File: src/charge_spreader.sv
// Charge spreader
`timescale 1ns/1ps

module charge_spreader (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic                                         accept,
  input  md_lr_pkg::particle_t                         particle,
  output logic                                         busy,
  output logic [md_lr_pkg::GADDRW-1:0]                 gm_x,
  output logic [md_lr_pkg::GADDRW-1:0]                 gm_y,
  output logic [md_lr_pkg::GADDRW-1:0]                 gm_z,
  output logic                                         gm_rd,
  output logic                                         gm_wr,
  output md_lr_pkg::grid_elem_t [md_lr_pkg::NNN3D-1:0] gm_wdata,
  input  md_lr_pkg::grid_elem_t [md_lr_pkg::NNN3D-1:0] gm_rdata
);

  import md_lr_pkg::*;

  logic       rd_q;                    // Neighbour read cycle
  logic       wr_q;                    // Write-back cycle
  particle_t  part_q;                  // Particle being spread
  grid_elem_t q_ext;                   // Charge at grid width

  // ----------------------------------------
  // Read then write sequence
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q <= 1'b0;
      wr_q <= 1'b0;
    end else begin
      rd_q <= accept;                  // Read follows the beat
      wr_q <= rd_q;                    // Write one cycle later
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      part_q <= particle;              // Capture with the load beat
    end
  end

  assign busy = rd_q | wr_q;

  // Same block address for read and write-back
  assign gm_x  = part_q.x;
  assign gm_y  = part_q.y;
  assign gm_z  = part_q.z;
  assign gm_rd = rd_q;
  assign gm_wr = wr_q;

  assign q_ext = {{(GELEW-QW){part_q.q[QW-1]}}, part_q.q}; // Sign extend

  // Every neighbour gets the full charge
  for (genvar n = 0; n < NNN3D; n++) begin : g_acc
    assign gm_wdata[n] = gm_rdata[n] + q_ext;
  end

endmodule

// File: src/clustered_grid_mem.sv
// Clustered eight-bank grid memory
`timescale 1ns/1ps

module clustered_grid_mem (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic                                             clr,
  input  logic [md_lr_pkg::BADDRW-1:0]                     clr_addr,
  input  logic [md_lr_pkg::GADDRW-1:0]                     base_x,
  input  logic [md_lr_pkg::GADDRW-1:0]                     base_y,
  input  logic [md_lr_pkg::GADDRW-1:0]                     base_z,
  input  logic                                             rd_en,
  input  logic                                             wr_en,
  input  md_lr_pkg::grid_elem_t [md_lr_pkg::NNN3D-1:0]     wdata,
  output md_lr_pkg::grid_elem_t [md_lr_pkg::NNN3D-1:0]     rdata
);

  import md_lr_pkg::*;

  logic [BADDRW-1:0] base_bank;        // Bank holding offset 000
  logic [BADDRW-1:0] base_bank_d;      // Same, aligned with read data
  grid_elem_t        bank_q [NNN3D];   // Raw bank outputs

  assign base_bank = bank_of(base_x, base_y, base_z);

  // Held while reads are idle so stalled data stays in order
  always_ff @(posedge clk) begin
    if (rst) begin
      base_bank_d <= '0;
    end else if (rd_en) begin
      base_bank_d <= base_bank;
    end
  end

  // ----------------------------------------
  // Bank array
  for (genvar b = 0; b < NNN3D; b++) begin : g_bank
    logic [BADDRW-1:0] nbr;            // Offset that lands in this bank
    logic [GADDRW-1:0] nx;
    logic [GADDRW-1:0] ny;
    logic [GADDRW-1:0] nz;
    logic [BADDRW-1:0] addr;
    grid_elem_t        bank_wdata;

    assign nbr = BADDRW'(b) ^ base_bank; // Low bit of c+d is c^d
    assign nx  = neighbour_coord(base_x, nbr[0]);
    assign ny  = neighbour_coord(base_y, nbr[1]);
    assign nz  = neighbour_coord(base_z, nbr[2]);

    assign addr       = clr ? clr_addr : bank_addr_of(nx, ny, nz); // Clear wins
    assign bank_wdata = clr ? '0 : wdata[nbr];

    bank_ram #(
      .DEPTH   (2 ** BADDRW),
      .entry_t (grid_elem_t)
    ) u_bank (
      .clk   (clk),
      .en    (clr | rd_en | wr_en),
      .we    (clr | wr_en),
      .addr  (addr),
      .wdata (bank_wdata),
      .rdata (bank_q[b])
    );
  end

  // ----------------------------------------
  // Back to neighbour order
  for (genvar n = 0; n < NNN3D; n++) begin : g_unperm
    assign rdata[n] = bank_q[BADDRW'(n) ^ base_bank_d];
  end

endmodule

// File: src/force_gather.sv
// Force gather pipeline
`timescale 1ns/1ps

module force_gather (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic                                         start,
  input  logic [md_lr_pkg::PADDRW-1:0]                 last_addr,
  output logic                                         pm_en,
  output logic [md_lr_pkg::PADDRW-1:0]                 pm_addr,
  input  md_lr_pkg::particle_t                         pm_rdata,
  output logic [md_lr_pkg::GADDRW-1:0]                 gm_x,
  output logic [md_lr_pkg::GADDRW-1:0]                 gm_y,
  output logic [md_lr_pkg::GADDRW-1:0]                 gm_z,
  output logic                                         gm_rd,
  input  md_lr_pkg::grid_elem_t [md_lr_pkg::NNN3D-1:0] gm_rdata,
  input  logic                                         fready,
  output logic                                         fvalid,
  output logic [md_lr_pkg::PADDRW-1:0]                 faddr,
  output logic                                         flast,
  output md_lr_pkg::force_t                            fdata,
  output logic                                         done
);

  import md_lr_pkg::*;

  logic              stall;            // Output held by the host
  logic              issue;            // Particle read this cycle
  logic              running;          // Address counter active
  logic [PADDRW-1:0] cnt;
  logic              cnt_last;         // Counter at round's end

  logic              s1_valid;         // Particle data out of memory
  logic              s1_last;
  logic [PADDRW-1:0] s1_addr;
  logic              s2_valid;         // Neighbour data out of grid
  logic              s2_last;
  logic [PADDRW-1:0] s2_addr;

  logic signed [FW-1:0] sum_x;
  logic signed [FW-1:0] sum_y;
  logic signed [FW-1:0] sum_z;

  assign stall    = fvalid & ~fready;
  assign issue    = running & ~stall;
  assign cnt_last = (cnt == last_addr);

  // ----------------------------------------
  // Stage 0 particle read
  assign pm_en   = issue;
  assign pm_addr = cnt;

  // ----------------------------------------
  // Stage 1 neighbour read
  assign gm_x  = pm_rdata.x;
  assign gm_y  = pm_rdata.y;
  assign gm_z  = pm_rdata.z;
  assign gm_rd = s1_valid & ~stall;    // Bank outputs hold in a stall

  // ----------------------------------------
  // Stage 2 gradient sums
  always_comb begin
    logic signed [FW-1:0] elem;
    sum_x = '0;
    sum_y = '0;
    sum_z = '0;
    for (int n = 0; n < NNN3D; n++) begin
      elem = {{(FW-GELEW){gm_rdata[n][GELEW-1]}}, gm_rdata[n]};
      sum_x = n[0] ? sum_x + elem : sum_x - elem; // Far side minus near
      sum_y = n[1] ? sum_y + elem : sum_y - elem;
      sum_z = n[2] ? sum_z + elem : sum_z - elem;
    end
  end

  // Counter and stage valids
  always_ff @(posedge clk) begin
    if (rst) begin
      running  <= 1'b0;
      cnt      <= '0;
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
      s2_valid <= 1'b0;
      s2_last  <= 1'b0;
      fvalid   <= 1'b0;
      flast    <= 1'b0;
    end else begin
      if (start) begin
        running <= 1'b1;
        cnt     <= '0;
      end else if (issue) begin
        cnt <= cnt + 1'b1;
        if (cnt_last) begin
          running <= 1'b0;             // Last address issued
        end
      end
      if (!stall) begin
        s1_valid <= issue;
        s1_last  <= issue & cnt_last;
        s2_valid <= s1_valid;
        s2_last  <= s1_last;
        fvalid   <= s2_valid;
        flast    <= s2_valid & s2_last;
      end
    end
  end

  // Stage payloads
  always_ff @(posedge clk) begin
    if (!stall) begin
      s1_addr  <= cnt;
      s2_addr  <= s1_addr;
      faddr    <= s2_addr;
      fdata.fx <= sum_x;
      fdata.fy <= sum_y;
      fdata.fz <= sum_z;
    end
  end

  assign done = fvalid & fready & flast; // Final transfer of the round

endmodule

// File: src/md_lr_pkg.sv
// Particle-mesh engine definitions
package md_lr_pkg;

  // ----------------------------------------
  // Grid geometry
  localparam int GSIZE1D = 4;                     // Cells per axis
  localparam int NNN1D   = 2;                     // Neighbours per axis
  localparam int NNN3D   = NNN1D * NNN1D * NNN1D; // 2x2x2 block
  localparam int GADDRW  = 2;                     // One coordinate
  localparam int BADDRW  = 3;                     // Address inside a bank

  // ----------------------------------------
  // Particle and data widths
  localparam int MAXNUMP = 16;                    // Particle memory depth
  localparam int PADDRW  = 4;                     // Particle address
  localparam int QW      = 8;                     // Charge
  localparam int GELEW   = 16;                    // Grid cell
  localparam int FW      = 18;                    // Force component

  typedef struct packed {
    logic        [GADDRW-1:0] z;
    logic        [GADDRW-1:0] y;
    logic        [GADDRW-1:0] x;
    logic signed [QW-1:0]     q;                  // Two's complement charge
  } particle_t;

  typedef logic signed [GELEW-1:0] grid_elem_t;

  typedef struct packed {
    logic signed [FW-1:0] fz;
    logic signed [FW-1:0] fy;
    logic signed [FW-1:0] fx;
  } force_t;

  // Low coordinate bits pick the bank, so a 2x2x2 block spans all eight
  function automatic logic [BADDRW-1:0] bank_of(
    input logic [GADDRW-1:0] x,
    input logic [GADDRW-1:0] y,
    input logic [GADDRW-1:0] z
  );
    return {z[0], y[0], x[0]};
  endfunction

  function automatic logic [BADDRW-1:0] bank_addr_of(
    input logic [GADDRW-1:0] x,
    input logic [GADDRW-1:0] y,
    input logic [GADDRW-1:0] z
  );
    return {z[GADDRW-1], y[GADDRW-1], x[GADDRW-1]};
  endfunction

  function automatic logic [GADDRW-1:0] neighbour_coord(
    input logic [GADDRW-1:0] c,
    input logic              off
  );
    return GADDRW'((int'(c) + int'(off)) % GSIZE1D); // Periodic wrap
  endfunction

endpackage

// File: src/md_lr_seqr.sv
// Load, gather and clear sequencer
`timescale 1ns/1ps

module md_lr_seqr (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         pvalid,
  input  logic [md_lr_pkg::PADDRW-1:0] paddr,
  input  logic                         plast,
  output logic                         pready,
  output logic                         accept,
  input  logic                         spread_busy,
  output logic                         gather_start,
  output logic [md_lr_pkg::PADDRW-1:0] last_addr,
  input  logic                         gather_done,
  output logic                         gm_clr,
  output logic [md_lr_pkg::BADDRW-1:0] gm_clr_addr,
  output logic                         gather_phase
);

  import md_lr_pkg::*;

  typedef enum logic [1:0] {
    PH_CLEAR,                          // Grid sweep
    PH_LOAD,                           // Host beats accepted
    PH_DRAIN,                          // Last spread finishing
    PH_GATHER                          // Forces streaming out
  } phase_t;

  phase_t            phase;
  logic [BADDRW-1:0] clr_cnt;          // Bank address under clear

  assign pready       = (phase == PH_LOAD) & ~spread_busy;
  assign accept       = pvalid & pready;
  assign gather_start = (phase == PH_DRAIN) & ~spread_busy; // Single pulse
  assign gather_phase = (phase == PH_GATHER);
  assign gm_clr       = (phase == PH_CLEAR);
  assign gm_clr_addr  = clr_cnt;

  // ----------------------------------------
  // Phase FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      phase   <= PH_CLEAR;             // Sweep first after reset
      clr_cnt <= '0;
    end else begin
      case (phase)
        PH_CLEAR: begin
          clr_cnt <= clr_cnt + 1'b1;   // Wraps back to zero
          if (clr_cnt == '1) begin
            phase <= PH_LOAD;
          end
        end
        PH_LOAD: begin
          if (accept && plast) begin
            phase <= PH_DRAIN;
          end
        end
        PH_DRAIN: begin
          if (!spread_busy) begin
            phase <= PH_GATHER;
          end
        end
        default: begin
          if (gather_done) begin
            phase <= PH_CLEAR;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept && plast) begin
      last_addr <= paddr;              // Round length for the gatherer
    end
  end

endmodule

// File: src/md_lr_top.sv
// Particle-mesh engine top level
`timescale 1ns/1ps

module md_lr_top (
  input  logic                         clk,
  input  logic                         rst,
  output logic                         pready,
  input  logic                         pvalid,
  input  logic [md_lr_pkg::PADDRW-1:0] paddr,
  input  md_lr_pkg::particle_t         pwdata,
  input  logic                         plast,
  input  logic                         fready,
  output logic                         fvalid,
  output logic [md_lr_pkg::PADDRW-1:0] faddr,
  output logic                         flast,
  output md_lr_pkg::force_t            fdata
);

  import md_lr_pkg::*;

  // Sequencer
  logic              accept;
  logic              spread_busy;
  logic              gather_start;
  logic [PADDRW-1:0] last_addr;
  logic              gather_done;
  logic              gm_clr;
  logic [BADDRW-1:0] gm_clr_addr;
  logic              gather_phase;

  // Particle memory
  logic              pm_en;
  logic [PADDRW-1:0] pm_addr;
  particle_t         pm_rdata;

  // Spreader grid port
  logic [GADDRW-1:0]             sp_x;
  logic [GADDRW-1:0]             sp_y;
  logic [GADDRW-1:0]             sp_z;
  logic                          sp_rd;
  logic                          sp_wr;
  grid_elem_t [NNN3D-1:0]        sp_wdata;

  // Gatherer grid port
  logic [GADDRW-1:0]             ga_x;
  logic [GADDRW-1:0]             ga_y;
  logic [GADDRW-1:0]             ga_z;
  logic                          ga_rd;

  // Shared grid port
  logic [GADDRW-1:0]             gm_x;
  logic [GADDRW-1:0]             gm_y;
  logic [GADDRW-1:0]             gm_z;
  logic                          gm_rd;
  logic                          gm_wr;
  grid_elem_t [NNN3D-1:0]        gm_rdata;

  // ----------------------------------------
  // Particle memory
  bank_ram #(
    .DEPTH   (MAXNUMP),
    .entry_t (particle_t)
  ) u_particle_mem (
    .clk   (clk),
    .en    (accept | pm_en),
    .we    (accept),                    // Every accepted beat writes
    .addr  (accept ? paddr : pm_addr),
    .wdata (pwdata),
    .rdata (pm_rdata)
  );

  md_lr_seqr u_seqr (
    .clk          (clk),
    .rst          (rst),
    .pvalid       (pvalid),
    .paddr        (paddr),
    .plast        (plast),
    .pready       (pready),
    .accept       (accept),
    .spread_busy  (spread_busy),
    .gather_start (gather_start),
    .last_addr    (last_addr),
    .gather_done  (gather_done),
    .gm_clr       (gm_clr),
    .gm_clr_addr  (gm_clr_addr),
    .gather_phase (gather_phase)
  );

  charge_spreader u_spreader (
    .clk      (clk),
    .rst      (rst),
    .accept   (accept),
    .particle (pwdata),
    .busy     (spread_busy),
    .gm_x     (sp_x),
    .gm_y     (sp_y),
    .gm_z     (sp_z),
    .gm_rd    (sp_rd),
    .gm_wr    (sp_wr),
    .gm_wdata (sp_wdata),
    .gm_rdata (gm_rdata)
  );

  // ----------------------------------------
  // Grid port mux
  assign gm_x  = gather_phase ? ga_x : sp_x;
  assign gm_y  = gather_phase ? ga_y : sp_y;
  assign gm_z  = gather_phase ? ga_z : sp_z;
  assign gm_rd = gather_phase ? ga_rd : sp_rd;
  assign gm_wr = ~gather_phase & sp_wr; // Gather side only reads

  clustered_grid_mem u_grid_mem (
    .clk      (clk),
    .rst      (rst),
    .clr      (gm_clr),
    .clr_addr (gm_clr_addr),
    .base_x   (gm_x),
    .base_y   (gm_y),
    .base_z   (gm_z),
    .rd_en    (gm_rd),
    .wr_en    (gm_wr),
    .wdata    (sp_wdata),
    .rdata    (gm_rdata)
  );

  force_gather u_gather (
    .clk       (clk),
    .rst       (rst),
    .start     (gather_start),
    .last_addr (last_addr),
    .pm_en     (pm_en),
    .pm_addr   (pm_addr),
    .pm_rdata  (pm_rdata),
    .gm_x      (ga_x),
    .gm_y      (ga_y),
    .gm_z      (ga_z),
    .gm_rd     (ga_rd),
    .gm_rdata  (gm_rdata),
    .fready    (fready),
    .fvalid    (fvalid),
    .faddr     (faddr),
    .flast     (flast),
    .fdata     (fdata),
    .done      (gather_done)
  );

endmodule

// File: verification/md_lr_stim.txt
// One particle per line as hex digits round addr x y z then a two-digit charge
// Lines of one round are contiguous with addresses counting up from zero
0033340
0133315
02000e0
031207f
0421381
0503122
06302f6
0711133
0822205
0911133
0a310c8
0b02319
0c2319c
0d1030a
0e32164
0f012ff
1022210
11300f0
120332a
13123d5
1433050
1533050
160018a
1721007
18132e2
193133c
1a020a6
1b20311

// File: verification/md_lr_tb.sv
// Particle-mesh engine testbench
`timescale 1ns/1ps

module md_lr_tb;

  import md_lr_pkg::*;

  localparam int NREC    = 28;                   // Particle records in the file
  localparam int MAX_CYC = 50 * NREC + 200;      // Run limit in cycles
  localparam int CLR_CYC = 8;                    // Grid sweep length

  logic              clk = 1'b0;
  logic              rst;
  logic              pready;
  logic              pvalid;
  logic [PADDRW-1:0] paddr;
  particle_t         pwdata;
  logic              plast;
  logic              fready;
  logic              fvalid;
  logic [PADDRW-1:0] faddr;
  logic              flast;
  force_t            fdata;

  logic [27:0]       stim_mem [NREC];            // Round addr x y z q
  int                grid [GSIZE1D][GSIZE1D][GSIZE1D]; // Model cells [z][y][x]
  int                exp_fx [MAXNUMP];
  int                exp_fy [MAXNUMP];
  int                exp_fz [MAXNUMP];
  int                round_len;                  // Particles in this round
  int                xfer_cnt;                   // Forces taken so far
  int                cyc_cnt  = 0;
  int                low_cnt  = CLR_CYC;         // Reset sweep comes first
  bit                high_due = 1'b0;            // pready must rise now
  bit                locked   = 1'b0;            // Between plast and last force
  bit                hold_due = 1'b0;            // Stalled result pending
  logic [PADDRW-1:0] held_addr;
  logic              held_last;
  force_t            held_data;
  int                seed     = 71544;
  int                rec_lo;
  int                rec_hi;

  md_lr_top i_dut (
    .clk    (clk),
    .rst    (rst),
    .pready (pready),
    .pvalid (pvalid),
    .paddr  (paddr),
    .pwdata (pwdata),
    .plast  (plast),
    .fready (fready),
    .fvalid (fvalid),
    .faddr  (faddr),
    .flast  (flast),
    .fdata  (fdata)
  );

  always #4 clk = ~clk;                          // 8 ns period

  always @(posedge clk) begin
    #1 fready = ($random(seed) % 4) != 0;        // Ready about 3 cycles in 4
  end

  // ----------------------------------------
  // Error reporting
  task automatic stop_on_error();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("%s at time %0t", msg, $time);
    stop_on_error();
  endtask

  task automatic check_value(input string name, input int exp_v, input int act_v);
    assert (act_v == exp_v) else begin
      $display("[FAIL] time %0t %s expected %0d actual %0d", $time, name, exp_v, act_v);
      stop_on_error();
    end
  endtask

  // ----------------------------------------
  // Reference model
  task automatic build_model(input int lo, input int hi);
    int x;
    int y;
    int z;
    int q;
    int a;
    int v;
    foreach (grid[i, j, k]) grid[i][j][k] = 0;   // Fresh grid every round
    for (int r = lo; r <= hi; r++) begin
      x = int'(stim_mem[r][17:16]);
      y = int'(stim_mem[r][13:12]);
      z = int'(stim_mem[r][9:8]);
      q = int'($signed(stim_mem[r][7:0]));
      for (int dz = 0; dz < NNN1D; dz++)
        for (int dy = 0; dy < NNN1D; dy++)
          for (int dx = 0; dx < NNN1D; dx++)
            grid[(z + dz) % GSIZE1D][(y + dy) % GSIZE1D][(x + dx) % GSIZE1D] += q;
    end
    for (int r = lo; r <= hi; r++) begin
      x = int'(stim_mem[r][17:16]);
      y = int'(stim_mem[r][13:12]);
      z = int'(stim_mem[r][9:8]);
      a = int'(stim_mem[r][23:20]);
      exp_fx[a] = 0;
      exp_fy[a] = 0;
      exp_fz[a] = 0;
      for (int dz = 0; dz < NNN1D; dz++)
        for (int dy = 0; dy < NNN1D; dy++)
          for (int dx = 0; dx < NNN1D; dx++) begin
            v = grid[(z + dz) % GSIZE1D][(y + dy) % GSIZE1D][(x + dx) % GSIZE1D];
            exp_fx[a] += (dx == 1) ? v : -v;     // Far face minus near face
            exp_fy[a] += (dy == 1) ? v : -v;
            exp_fz[a] += (dz == 1) ? v : -v;
          end
    end
  endtask

  // ----------------------------------------
  // Load port driver
  task automatic send_beat(input int rec, input bit is_last);
    pvalid = 1'b1;
    paddr  = stim_mem[rec][23:20];
    pwdata = {stim_mem[rec][9:8], stim_mem[rec][13:12], stim_mem[rec][17:16],
              stim_mem[rec][7:0]};               // z y x q
    plast  = is_last;
    do begin
      @(negedge clk);
    end while (!pready);
    @(posedge clk);                              // Beat taken on this edge
    #1;
    pvalid = 1'b0;
    plast  = 1'b0;
  endtask

  // ----------------------------------------
  // Output monitors sampled mid-cycle
  task automatic check_pready();
    if (locked || low_cnt > 0) begin
      check_value("pready", 0, int'(pready));
      if (!locked) begin
        low_cnt--;
        high_due = (low_cnt == 0);
      end
    end else if (high_due) begin
      check_value("pready", 1, int'(pready));
      high_due = 1'b0;
    end
    if (pvalid && pready) begin
      if (plast) begin
        locked = 1'b1;                           // Held low through the gather
      end else begin
        low_cnt = 2;                             // Spread read and write-back
      end
    end
  endtask

  task automatic check_force();
    if (hold_due) begin
      assert (fvalid) else report_error("fvalid dropped before its result transferred");
      check_value("faddr", int'(held_addr), int'(faddr));
      check_value("flast", int'(held_last), int'(flast));
      check_value("fdata.fx", int'(held_data.fx), int'(fdata.fx));
      check_value("fdata.fy", int'(held_data.fy), int'(fdata.fy));
      check_value("fdata.fz", int'(held_data.fz), int'(fdata.fz));
    end
    hold_due = fvalid && !fready;
    if (hold_due) begin
      held_addr = faddr;
      held_last = flast;
      held_data = fdata;
    end
    if (fvalid && fready) begin
      assert (xfer_cnt < round_len) else report_error("Force result beyond the round's end");
      check_value("faddr", xfer_cnt, int'(faddr));
      check_value("flast", int'(xfer_cnt == round_len - 1), int'(flast));
      check_value("fdata.fx", exp_fx[xfer_cnt], int'(fdata.fx));
      check_value("fdata.fy", exp_fy[xfer_cnt], int'(fdata.fy));
      check_value("fdata.fz", exp_fz[xfer_cnt], int'(fdata.fz));
      xfer_cnt++;
      if (flast) begin
        locked  = 1'b0;
        low_cnt = CLR_CYC;                       // Clear sweep before next load
      end
    end
  endtask

  always @(negedge clk) begin
    cyc_cnt++;
    if (cyc_cnt >= MAX_CYC) begin
      report_error("Run exceeded the cycle limit without finishing");
    end
    if (!rst) begin
      check_pready();
      check_force();
    end
  end

  // ----------------------------------------
  // Main sequence
  initial begin
    rst       = 1'b1;
    pvalid    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    plast     = 1'b0;
    fready    = 1'b0;
    round_len = 0;
    xfer_cnt  = 0;
    $readmemh("verification/md_lr_stim.txt", stim_mem);
    repeat (8) @(posedge clk);
    #1;
    rst    = 1'b0;
    rec_lo = 0;
    while (rec_lo < NREC) begin
      rec_hi = rec_lo;
      while (rec_hi + 1 < NREC && stim_mem[rec_hi + 1][27:24] == stim_mem[rec_lo][27:24]) begin
        rec_hi++;                                // Same round digit
      end
      build_model(rec_lo, rec_hi);
      xfer_cnt  = 0;
      round_len = rec_hi - rec_lo + 1;
      for (int r = rec_lo; r <= rec_hi; r++) begin
        send_beat(r, r == rec_hi);
      end
      while (xfer_cnt < round_len) begin
        @(posedge clk);
        #1;
      end
      rec_lo = rec_hi + 1;
    end
    repeat (CLR_CYC + 4) @(posedge clk);         // Final sweep and pready rise
    $display("All tests passed");
    $finish;
  end

endmodule
